// ==== hw/pwm_chain.sv ====
`include "pwm_config.svh"

module pwm_chain import pwm_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           tick,
    pwm_chain_cfg_if.chain cfg,
    output chain_raw_t     pwm_raw
);

    count_t                  cnt_q;
    logic [`PWM_CHANNELS-1:0] in_window;
    chain_raw_t              raw_next;

    // Period counter runs 0 to period inclusive, so one output period is period+1 ticks
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (!cfg.enable) begin
            cnt_q <= '0;
        end else if (tick) begin
            if (cnt_q >= cfg.period) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Window is half open, high from compare_low up to but not including compare_high
    // An empty or inverted window never goes high
    always_comb begin
        for (int c = 0; c < `PWM_CHANNELS; c++) begin
            in_window[c] = (cnt_q >= cfg.compare_low[c]) && (cnt_q < cfg.compare_high[c]);
            raw_next[2*c] = in_window[c];
            raw_next[2*c+1] = ~in_window[c];
        end
    end

    // Outputs follow the counter one cycle later
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pwm_raw <= '0;
        end else begin
            pwm_raw <= raw_next;
        end
    end

endmodule

// ==== hw/pwm_chain_cfg_if.sv ====
`include "pwm_config.svh"

// Static configuration of one PWM chain
// The register file owns every signal and the chain only samples them
interface pwm_chain_cfg_if;

    // Last counter value before the wrap to zero
    logic [`PWM_CNT_W-1:0] period;

    // Chain run enable, the counter is held at zero while low
    logic                  enable;

    // Window start per channel, included in the high phase
    logic [`PWM_CNT_W-1:0] compare_low [`PWM_CHANNELS];

    // Window end per channel, excluded from the high phase
    logic [`PWM_CNT_W-1:0] compare_high [`PWM_CHANNELS];

    modport regs (
        output period,
        output enable,
        output compare_low,
        output compare_high
    );

    modport chain (
        input period,
        input enable,
        input compare_low,
        input compare_high
    );

endinterface

// ==== hw/pwm_config.svh ====
`ifndef PWM_CONFIG_SVH
`define PWM_CONFIG_SVH

// Number of independent PWM chains built by the top level
`define PWM_N_CHAINS 2

// Compare-window channels inside each chain
// Every channel gives a true output and its complement
`define PWM_CHANNELS 3

// Width of the period counter and of the compare values
// The compare pair register packs two of these into one 32-bit word
`define PWM_CNT_W 16

// APB address width
// Bits 11:8 select the register page and bits 7:0 the register inside it
`define PWM_ADDR_W 12

`endif

// ==== hw/pwm_generator.sv ====
`include "pwm_config.svh"

module pwm_generator import pwm_pkg::*; (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`PWM_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   fault,
    output pwm_bus_t               pwm_out
);

    logic        timebase_enable;
    prescale_t   prescale;
    chain_mask_t chain_enable;
    logic        fault_clear;
    logic        fault_latched;
    logic        tick;
    chain_raw_t  pwm_raw [`PWM_N_CHAINS];

    // One configuration bundle per chain, all written by the register file
    pwm_chain_cfg_if chain_cfg [`PWM_N_CHAINS] ();

    pwm_regfile regfile_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .fault_latched   (fault_latched),
        .timebase_enable (timebase_enable),
        .prescale        (prescale),
        .chain_enable    (chain_enable),
        .fault_clear     (fault_clear),
        .cfg             (chain_cfg)
    );

    // Shared tick keeps all chains in phase
    pwm_timebase timebase_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .enable   (timebase_enable),
        .prescale (prescale),
        .tick     (tick)
    );

    for (genvar g = 0; g < `PWM_N_CHAINS; g++) begin : g_chain
        pwm_chain chain_i (
            .clock   (clock),
            .rst_n   (rst_n),
            .tick    (tick),
            .cfg     (chain_cfg[g]),
            .pwm_raw (pwm_raw[g])
        );
    end

    pwm_output_stage output_stage_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .pwm_raw       (pwm_raw),
        .chain_enable  (chain_enable),
        .fault         (fault),
        .fault_clear   (fault_clear),
        .pwm_out       (pwm_out),
        .fault_latched (fault_latched)
    );

endmodule

// ==== hw/pwm_output_stage.sv ====
`include "pwm_config.svh"

module pwm_output_stage import pwm_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  chain_raw_t  pwm_raw [`PWM_N_CHAINS],
    input  chain_mask_t chain_enable,
    input  logic        fault,
    input  logic        fault_clear,
    output pwm_bus_t    pwm_out,
    output logic        fault_latched
);

    localparam int RAW_W = 2 * `PWM_CHANNELS;

    pwm_bus_t gated;
    logic     trip;

    // The live fault input trips together with the latch
    // so outputs drop at the same edge that sets it
    assign trip = fault | fault_latched;

    always_comb begin
        gated = '0;
        if (!trip) begin
            for (int g = 0; g < `PWM_N_CHAINS; g++) begin
                if (chain_enable[g]) begin
                    gated[g*RAW_W +: RAW_W] = pwm_raw[g];
                end
            end
        end
    end

    // Fault latch, a clear request loses against an active fault
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fault_latched <= 1'b0;
        end else if (fault) begin
            fault_latched <= 1'b1;
        end else if (fault_clear) begin
            fault_latched <= 1'b0;
        end
    end

    // Final register toward the pins
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pwm_out <= '0;
        end else begin
            pwm_out <= gated;
        end
    end

endmodule

// ==== hw/pwm_pkg.sv ====
`include "pwm_config.svh"

package pwm_pkg;

    // Clock divider setting of the timebase, fixed by the global register layout
    typedef logic [7:0] prescale_t;

    // Period counter and compare value
    typedef logic [`PWM_CNT_W-1:0] count_t;

    // One enable bit per chain
    typedef logic [`PWM_N_CHAINS-1:0] chain_mask_t;

    // Raw outputs of one chain with true on even bits and complement on odd bits
    typedef logic [2*`PWM_CHANNELS-1:0] chain_raw_t;

    // All outputs of the generator, chain 0 in the lowest bits
    typedef logic [`PWM_N_CHAINS*2*`PWM_CHANNELS-1:0] pwm_bus_t;

    // Global control word at offset 0x000
    typedef struct packed {
        logic [31-16-`PWM_N_CHAINS:0] reserved_hi;
        chain_mask_t                  chain_enable;
        prescale_t                    prescale;
        logic [5:0]                   reserved_lo;
        logic                         fault_clear;
        logic                         timebase_enable;
    } global_ctrl_t;

    // Chain control word with the counter period in the low bits
    typedef struct packed {
        logic [31-`PWM_CNT_W:0] reserved;
        count_t                 period;
    } chain_ctrl_t;

    // Compare window of one channel, high edge in the upper half
    typedef struct packed {
        count_t compare_high;
        count_t compare_low;
    } compare_pair_t;

    // A chain register write is read either as control or as a compare pair
    typedef union packed {
        chain_ctrl_t   ctrl;
        compare_pair_t cmp;
    } chain_reg_word_t;

    // Register map
    // Chain registers are listed at their chain 0 address and repeat every 0x100
    typedef enum logic [`PWM_ADDR_W-1:0] {
        REG_GLOBAL_CTRL = 'h000,
        REG_STATUS      = 'h004,
        REG_CHAIN_CTRL  = 'h100,
        REG_CHAIN_CMP0  = 'h104,
        REG_CHAIN_CMP1  = 'h108,
        REG_CHAIN_CMP2  = 'h10C
    } reg_offset_e;

endpackage

// ==== hw/pwm_regfile.sv ====
`include "pwm_config.svh"

module pwm_regfile import pwm_pkg::*; (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`PWM_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   fault_latched,
    output logic                   timebase_enable,
    output prescale_t              prescale,
    output chain_mask_t            chain_enable,
    output logic                   fault_clear,
    pwm_chain_cfg_if.regs          cfg [`PWM_N_CHAINS]
);

    localparam int CH_W = (`PWM_N_CHAINS > 1) ? $clog2(`PWM_N_CHAINS) : 1;
    localparam int PAGE_W = `PWM_ADDR_W - 8;

    logic [PAGE_W-1:0]      page;
    logic                   page_ok;
    logic [CH_W-1:0]        chain_sel;
    logic [1:0]             chan_sel;
    logic [`PWM_ADDR_W-1:0] norm_addr;
    reg_offset_e            reg_sel;
    logic                   addr_ok;
    logic                   access;
    logic                   wr_en;
    logic [31:0]            rd_data;
    chain_reg_word_t        wr_word;
    chain_reg_word_t        rd_word;
    global_ctrl_t           wr_global;
    global_ctrl_t           global_next;
    global_ctrl_t           global_q;

    count_t period_q [`PWM_N_CHAINS];
    count_t cmp_low_q [`PWM_N_CHAINS][`PWM_CHANNELS];
    count_t cmp_high_q [`PWM_N_CHAINS][`PWM_CHANNELS];

    // No wait states, every transfer ends in its access cycle
    assign pready = 1'b1;
    assign access = psel & penable;
    assign wr_en = access & pwrite & addr_ok;
    assign pslverr = access & ~addr_ok;
    assign prdata = rd_data;

    always_comb begin
        page = paddr[`PWM_ADDR_W-1:8];
        page_ok = (page >= PAGE_W'(1)) && (page <= PAGE_W'(`PWM_N_CHAINS));
        // Page 1 is chain 0, so the low bits minus one give the chain index
        chain_sel = page[CH_W-1:0] - CH_W'(1);
        // Compare pairs start at offset 0x04 for channel 0
        chan_sel = paddr[3:2] - 2'd1;
        // Every chain page folds onto the chain 0 page before the lookup
        if (page == '0) begin
            norm_addr = paddr;
        end else begin
            norm_addr = {PAGE_W'(1), paddr[7:0]};
        end
        reg_sel = reg_offset_e'(norm_addr);

        addr_ok = 1'b0;
        rd_word = '0;
        rd_data = '0;
        case (reg_sel)
            REG_GLOBAL_CTRL: begin
                addr_ok = 1'b1;
                rd_data = global_q;
            end
            REG_STATUS: begin
                addr_ok = 1'b1;
                rd_data = {31'b0, fault_latched};
            end
            REG_CHAIN_CTRL: begin
                addr_ok = page_ok;
                rd_word.ctrl.period = period_q[chain_sel];
                rd_data = rd_word;
            end
            REG_CHAIN_CMP0, REG_CHAIN_CMP1, REG_CHAIN_CMP2: begin
                addr_ok = page_ok;
                rd_word.cmp.compare_low = cmp_low_q[chain_sel][chan_sel];
                rd_word.cmp.compare_high = cmp_high_q[chain_sel][chan_sel];
                rd_data = rd_word;
            end
            default: ;
        endcase
    end

    // Views of the write data, the union picks control or compare fields
    always_comb begin
        wr_word = pwdata;
        wr_global = global_ctrl_t'(pwdata);
        // Only the defined global fields are stored, fault_clear is a strobe
        global_next = '0;
        global_next.timebase_enable = wr_global.timebase_enable;
        global_next.prescale = wr_global.prescale;
        global_next.chain_enable = wr_global.chain_enable;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            global_q <= '0;
            fault_clear <= 1'b0;
            for (int i = 0; i < `PWM_N_CHAINS; i++) begin
                period_q[i] <= '0;
                for (int j = 0; j < `PWM_CHANNELS; j++) begin
                    cmp_low_q[i][j] <= '0;
                    cmp_high_q[i][j] <= '0;
                end
            end
        end else begin
            // Single-cycle pulse, the output stage decides if the latch may clear
            fault_clear <= wr_en && (reg_sel == REG_GLOBAL_CTRL) && wr_global.fault_clear;
            if (wr_en) begin
                case (reg_sel)
                    REG_GLOBAL_CTRL: global_q <= global_next;
                    REG_CHAIN_CTRL: period_q[chain_sel] <= wr_word.ctrl.period;
                    REG_CHAIN_CMP0, REG_CHAIN_CMP1, REG_CHAIN_CMP2: begin
                        cmp_low_q[chain_sel][chan_sel] <= wr_word.cmp.compare_low;
                        cmp_high_q[chain_sel][chan_sel] <= wr_word.cmp.compare_high;
                    end
                    // Status is read-only and writes to it are ignored
                    default: ;
                endcase
            end
        end
    end

    assign timebase_enable = global_q.timebase_enable;
    assign prescale = global_q.prescale;
    assign chain_enable = global_q.chain_enable;

    // Fan the stored settings out to the per-chain interfaces
    for (genvar g = 0; g < `PWM_N_CHAINS; g++) begin : g_cfg
        assign cfg[g].period = period_q[g];
        assign cfg[g].enable = global_q.chain_enable[g];
        for (genvar c = 0; c < `PWM_CHANNELS; c++) begin : g_chan
            assign cfg[g].compare_low[c] = cmp_low_q[g][c];
            assign cfg[g].compare_high[c] = cmp_high_q[g][c];
        end
    end

endmodule

// ==== hw/pwm_timebase.sv ====
`include "pwm_config.svh"

module pwm_timebase import pwm_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      enable,
    input  prescale_t prescale,
    output logic      tick
);

    // Cycles since the last tick
    prescale_t div_q;
    logic      wrap;

    // The compare is open ended so a prescale lowered mid count still wraps at once
    assign wrap = (div_q >= prescale);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            div_q <= '0;
            tick <= 1'b0;
        end else if (!enable) begin
            // A stopped timebase restarts from a clean phase
            div_q <= '0;
            tick <= 1'b0;
        end else if (wrap) begin
            div_q <= '0;
            tick <= 1'b1;
        end else begin
            div_q <= div_q + 1'b1;
            tick <= 1'b0;
        end
    end

    // With prescale at zero tick stays high and every cycle counts
    // Otherwise tick is high for one cycle out of prescale+1

endmodule

// ==== pwm_generator.f ====
+incdir+hw
hw/pwm_pkg.sv
hw/pwm_chain_cfg_if.sv
hw/pwm_regfile.sv
hw/pwm_timebase.sv
hw/pwm_chain.sv
hw/pwm_output_stage.sv
hw/pwm_generator.sv
verification/pwm_generator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f pwm_generator.f --top-module pwm_generator_tb -o pwm_generator_sim &&
sim_out="$(./obj_dir/pwm_generator_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1

// ==== verification/pwm_generator_tb.sv ====
`include "pwm_config.svh"

module pwm_generator_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAW_W = 2 * `PWM_CHANNELS;
    localparam int OUT_W = `PWM_N_CHAINS * RAW_W;
    // Roughly twice the cycles spent in all measured periods and register accesses
    localparam int TIMEOUT_CYCLES = 4000;

    logic                   clock;
    logic                   rst_n;
    logic [`PWM_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   fault;
    logic [OUT_W-1:0]       pwm_out;

    int                      seed;
    int                      cycle_cnt = 0;
    logic [`PWM_N_CHAINS-1:0] compl_mask;
    logic [OUT_W-1:0]        snap;
    int                      chain_period [`PWM_N_CHAINS];
    int                      win_lo [`PWM_N_CHAINS][`PWM_CHANNELS];
    int                      win_hi [`PWM_N_CHAINS][`PWM_CHANNELS];

    pwm_generator dut_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .fault   (fault),
        .pwm_out (pwm_out)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    // Cycle limit that ends a run which would otherwise never finish
    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout reached after %0d cycles before the tests finished", cycle_cnt);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // While a chain is enabled and free of faults each odd output mirrors its even partner
    always @(negedge clock) begin
        for (int g = 0; g < `PWM_N_CHAINS; g++) begin
            for (int c = 0; c < `PWM_CHANNELS; c++) begin
                if (compl_mask[g]) begin
                    assert (pwm_out[g*RAW_W+2*c+1] === ~pwm_out[g*RAW_W+2*c])
                    else report_mismatch($sformatf("pwm_out[%0d]", g*RAW_W+2*c+1),
                                         1'(~pwm_out[g*RAW_W+2*c]),
                                         pwm_out[g*RAW_W+2*c+1]);
                end
            end
        end
    end

    function automatic logic [`PWM_ADDR_W-1:0] chain_addr(input int g, input int offset);
        return `PWM_ADDR_W'((g + 1) * 'h100 + offset);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    // One APB transfer as a setup cycle and an access cycle
    // pready and pslverr are checked in the middle of the access cycle
    task automatic apb_transfer(input logic [`PWM_ADDR_W-1:0] addr, input logic write,
                                input logic [31:0] data, input logic exp_err,
                                output logic [31:0] rdata);
        @(posedge clock);
        #1;
        paddr = addr;
        pwrite = write;
        pwdata = data;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #1;
        penable = 1'b1;
        @(negedge clock);
        rdata = prdata;
        assert (pready === 1'b1) else report_mismatch("pready", 1, pready);
        assert (pslverr === exp_err) else report_mismatch("pslverr", exp_err, pslverr);
        @(posedge clock);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input logic [`PWM_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_transfer(addr, 1'b1, data, exp_err, unused);
    endtask

    task automatic expect_read(input logic [`PWM_ADDR_W-1:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        apb_transfer(addr, 1'b0, 32'h0, 1'b0, data);
        assert (data === exp)
        else report_mismatch($sformatf("prdata at 0x%03h", addr), exp, data);
    endtask

    // Random window with compare_low below compare_high and compare_high at most period
    task automatic program_windows();
        int r;
        for (int g = 0; g < `PWM_N_CHAINS; g++) begin
            for (int c = 0; c < `PWM_CHANNELS; c++) begin
                r = $random(seed);
                win_lo[g][c] = (r & 'h7fff_ffff) % chain_period[g];
                r = $random(seed);
                win_hi[g][c] = win_lo[g][c] + 1
                               + (r & 'h7fff_ffff) % (chain_period[g] - win_lo[g][c]);
                write_reg(chain_addr(g, 4 + 4 * c),
                          32'((win_hi[g][c] << 16) | win_lo[g][c]), 1'b0);
            end
        end
    endtask

    // Returns at the negedge that first sees the output high after a low cycle
    task automatic wait_rise(input int bit_idx);
        logic prev;
        @(negedge clock);
        prev = pwm_out[bit_idx];
        @(negedge clock);
        while (!(pwm_out[bit_idx] && !prev)) begin
            prev = pwm_out[bit_idx];
            @(negedge clock);
        end
    endtask

    // Reference duty counter over one output period measured from rising edge to rising edge
    task automatic measure_duty(input int bit_idx, input int exp_period, input int exp_high);
        int   period_cnt;
        int   high_cnt;
        logic prev;
        period_cnt = 0;
        high_cnt = 0;
        prev = 1'b0;
        // The first edge may still belong to the previous settings
        wait_rise(bit_idx);
        wait_rise(bit_idx);
        do begin
            high_cnt += int'(pwm_out[bit_idx]);
            period_cnt++;
            prev = pwm_out[bit_idx];
            @(negedge clock);
        end while (!(pwm_out[bit_idx] && !prev));
        assert (period_cnt == exp_period)
        else report_mismatch($sformatf("pwm_out[%0d] period", bit_idx), exp_period, period_cnt);
        assert (high_cnt == exp_high)
        else report_mismatch($sformatf("pwm_out[%0d] high cycles", bit_idx), exp_high, high_cnt);
    endtask

    task automatic check_duty(input int prescale);
        for (int g = 0; g < `PWM_N_CHAINS; g++) begin
            for (int c = 0; c < `PWM_CHANNELS; c++) begin
                measure_duty(g * RAW_W + 2 * c, (chain_period[g] + 1) * (prescale + 1),
                             (win_hi[g][c] - win_lo[g][c]) * (prescale + 1));
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        fault = 1'b0;
        compl_mask = '0;
        seed = 55;
        chain_period[0] = 9;
        chain_period[1] = 14;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(negedge clock);
        assert (pwm_out === '0) else report_mismatch("pwm_out after reset", 0, pwm_out);

        // Status is clear and every written register reads back unchanged
        expect_read('h004, 32'h0);
        for (int g = 0; g < `PWM_N_CHAINS; g++) begin
            write_reg(chain_addr(g, 0), chain_period[g], 1'b0);
        end
        program_windows();
        write_reg('h000, 32'h0000_0500, 1'b0);
        for (int g = 0; g < `PWM_N_CHAINS; g++) begin
            expect_read(chain_addr(g, 0), chain_period[g]);
            for (int c = 0; c < `PWM_CHANNELS; c++) begin
                expect_read(chain_addr(g, 4 + 4 * c), 32'((win_hi[g][c] << 16) | win_lo[g][c]));
            end
        end
        expect_read('h000, 32'h0000_0500);

        // Accesses outside the map report an error and write nothing
        write_reg('h300, 32'hDEAD_BEEF, 1'b1);
        write_reg('h010, 32'hDEAD_BEEF, 1'b1);
        write_reg('h110, 32'hDEAD_BEEF, 1'b1);
        expect_read(chain_addr(0, 0), chain_period[0]);
        expect_read('h000, 32'h0000_0500);

        // Both chains run first at full clock rate and then divided by four
        write_reg('h000, 32'h0003_0001, 1'b0);
        wait_cycles(3);
        compl_mask = '1;
        check_duty(0);
        program_windows();
        write_reg('h000, 32'h0003_0301, 1'b0);
        check_duty(3);

        // Chain 1 switched off goes low and stays there
        compl_mask = 2'b01;
        write_reg('h000, 32'h0001_0301, 1'b0);
        wait_cycles(3);
        repeat (20) begin
            @(negedge clock);
            assert (pwm_out[OUT_W-1:RAW_W] === '0)
            else report_mismatch("pwm_out chain 1", 0, pwm_out[OUT_W-1:RAW_W]);
        end
        // A stopped timebase freezes the running chain where it is
        write_reg('h000, 32'h0001_0300, 1'b0);
        wait_cycles(3);
        @(negedge clock);
        snap = pwm_out;
        // A whole output period is watched, in which a running counter would move every channel
        repeat ((chain_period[0] + 1) * 4) begin
            @(negedge clock);
            assert (pwm_out[RAW_W-1:0] === snap[RAW_W-1:0])
            else report_mismatch("pwm_out chain 0", snap[RAW_W-1:0], pwm_out[RAW_W-1:0]);
        end
        write_reg('h000, 32'h0003_0001, 1'b0);
        wait_cycles(3);
        compl_mask = '1;
        wait_cycles(10);

        // Fault pulse blanks every output from the next edge and latches
        @(posedge clock);
        #1;
        compl_mask = '0;
        fault = 1'b1;
        @(posedge clock);
        @(negedge clock);
        assert (pwm_out === '0) else report_mismatch("pwm_out on fault", 0, pwm_out);
        @(posedge clock);
        #1;
        fault = 1'b0;
        expect_read('h004, 32'h1);
        // Clearing while the fault is still present has no effect
        // The fault drops right after the clear strobe so a clear that won would stay visible
        fault = 1'b1;
        write_reg('h000, 32'h0003_0003, 1'b0);
        wait_cycles(1);
        #1;
        fault = 1'b0;
        expect_read('h004, 32'h1);
        @(negedge clock);
        assert (pwm_out === '0) else report_mismatch("pwm_out while latched", 0, pwm_out);
        // With the fault gone a clear brings the outputs back
        write_reg('h000, 32'h0003_0003, 1'b0);
        wait_cycles(3);
        expect_read('h004, 32'h0);
        expect_read('h000, 32'h0003_0001);
        @(negedge clock);
        assert (pwm_out !== '0) else report_mismatch("pwm_out after clear", 1, pwm_out);
        compl_mask = '1;
        wait_cycles(20);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
